//--- Makefile
# Verilator build and run of the sorter core testbench
TOP = tb_fads

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" sim.log; then echo "simulation gave no result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- common/fads_pkg.sv
// widths and register map shared by the sorter core; thresholds assumed ordered min <= low <= high
package fads_pkg;

    // signed adc sample, also used for intensity thresholds
    typedef logic signed [13:0] sample_t;
    // widths in samples and sort timing in clock cycles
    typedef logic [31:0] width_t;
    typedef logic [31:0] count_t;
    typedef logic [19:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    // class byte, bit 6 unused
    typedef logic [7:0] class_t;

    // threshold and timing registers, read/write
    localparam bus_addr_t ADDR_MIN_INT = 20'h00000;
    localparam bus_addr_t ADDR_LOW_INT = 20'h00004;
    localparam bus_addr_t ADDR_HIGH_INT = 20'h00008;
    localparam bus_addr_t ADDR_MIN_W = 20'h00010;
    localparam bus_addr_t ADDR_LOW_W = 20'h00014;
    localparam bus_addr_t ADDR_HIGH_W = 20'h00018;
    localparam bus_addr_t ADDR_SORT_DELAY = 20'h00024;
    localparam bus_addr_t ADDR_SORT_DUR = 20'h00028;

    // statistics, read only
    localparam bus_addr_t ADDR_CNT_LOW_INT = 20'h00100;
    localparam bus_addr_t ADDR_CNT_HIGH_INT = 20'h00104;
    localparam bus_addr_t ADDR_CNT_SHORT = 20'h00108;
    localparam bus_addr_t ADDR_CNT_LONG = 20'h0010C;
    localparam bus_addr_t ADDR_CNT_POS = 20'h00110;
    localparam bus_addr_t ADDR_CNT_NEG = 20'h00114;

    // last droplet record, read only
    localparam bus_addr_t ADDR_DROP_ID = 20'h00200;
    localparam bus_addr_t ADDR_DROP_INT = 20'h00204;
    localparam bus_addr_t ADDR_DROP_W = 20'h00208;
    localparam bus_addr_t ADDR_DROP_CLASS = 20'h0020C;

    // reset values
    localparam sample_t RST_MIN_INT = 14'sd15;
    localparam sample_t RST_LOW_INT = 14'sd16;
    localparam sample_t RST_HIGH_INT = 14'sd255;
    localparam width_t RST_MIN_W = 32'd1;
    localparam width_t RST_LOW_W = 32'd4;
    localparam width_t RST_HIGH_W = 32'd40;
    // 0.25 ms and 1 ms at 125 MHz
    localparam width_t RST_SORT_DELAY = 32'd31250;
    localparam width_t RST_SORT_DUR = 32'd125000;

endpackage

//--- droplet/droplet_classifier.sv
// band classifier; every reported peak already clears min_int, so low band only checks low_int
`timescale 1ns/1ns

module droplet_classifier (
    input  logic              adc_clk_i,
    input  logic              fads_reset,
    input  logic              drop_done_i,
    input  fads_pkg::sample_t drop_peak_i,
    input  fads_pkg::width_t  drop_width_i,
    input  fads_pkg::sample_t low_int_i,
    input  fads_pkg::sample_t high_int_i,
    input  fads_pkg::width_t  min_w_i,
    input  fads_pkg::width_t  low_w_i,
    input  fads_pkg::width_t  high_w_i,
    output fads_pkg::count_t  cnt_low_int_o,
    output fads_pkg::count_t  cnt_high_int_o,
    output fads_pkg::count_t  cnt_short_o,
    output fads_pkg::count_t  cnt_long_o,
    output fads_pkg::count_t  cnt_pos_o,
    output fads_pkg::count_t  cnt_neg_o,
    output fads_pkg::count_t  drop_id_o,
    output fads_pkg::sample_t last_peak_o,
    output fads_pkg::width_t  last_width_o,
    output fads_pkg::class_t  last_class_o,
    output logic              sort_start_o
);

    logic             int_low;
    logic             int_pos;
    logic             int_high;
    logic             w_short;
    logic             w_pos;
    logic             w_long;
    logic             has_width;
    logic             positive;
    logic             negative;
    fads_pkg::class_t cls;

    // intensity bands, signed
    assign int_low = drop_peak_i < low_int_i;
    assign int_pos = drop_peak_i >= low_int_i && drop_peak_i < high_int_i;
    assign int_high = drop_peak_i >= high_int_i;

    // width bands, below min_w gets no width class
    assign has_width = drop_width_i >= min_w_i;
    assign w_short = has_width && drop_width_i < low_w_i;
    assign w_pos = has_width && drop_width_i >= low_w_i && drop_width_i < high_w_i;
    assign w_long = has_width && drop_width_i >= high_w_i;

    assign positive = int_pos && w_pos;
    assign negative = has_width && !positive;

    assign cls = {positive, 1'b0, w_long, w_pos, w_short, int_high, int_pos, int_low};

    // same cycle as drop_done
    assign sort_start_o = drop_done_i && positive;

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            cnt_low_int_o <= '0;
            cnt_high_int_o <= '0;
            cnt_short_o <= '0;
            cnt_long_o <= '0;
            cnt_pos_o <= '0;
            cnt_neg_o <= '0;
            drop_id_o <= '0;
            last_peak_o <= '0;
            last_width_o <= '0;
            last_class_o <= '0;
        end else if (drop_done_i) begin
            cnt_low_int_o <= cnt_low_int_o + int_low;
            cnt_high_int_o <= cnt_high_int_o + int_high;
            cnt_short_o <= cnt_short_o + w_short;
            cnt_long_o <= cnt_long_o + w_long;
            cnt_pos_o <= cnt_pos_o + positive;
            cnt_neg_o <= cnt_neg_o + negative;
            // record only droplets with a width class
            if (positive || negative) begin
                drop_id_o <= drop_id_o + 32'd1;
                last_peak_o <= drop_peak_i;
                last_width_o <= drop_width_i;
                last_class_o <= cls;
            end
        end
    end

endmodule

//--- droplet/droplet_detector.sv
// droplet finder; a run is samples >= min_int, no new droplet while the sort timer is busy
`timescale 1ns/1ns

module droplet_detector (
    input  logic              adc_clk_i,
    input  logic              fads_reset,
    input  fads_pkg::sample_t adc_a_i,
    input  fads_pkg::sample_t min_int_i,
    input  logic              sort_busy_i,
    output logic              drop_done_o,
    output fads_pkg::sample_t drop_peak_o,
    output fads_pkg::width_t  drop_width_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        ACQUIRE,
        DONE,
        HOLD
    } det_state_t;

    det_state_t state;
    logic       above;

    // signed compare, threshold may be negative
    assign above = adc_a_i >= min_int_i;

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: state <= WAIT;
                WAIT: begin
                    if (above) begin
                        state <= ACQUIRE;
                    end
                end
                // first sample below min closes the run
                ACQUIRE: begin
                    if (!above) begin
                        state <= DONE;
                    end
                end
                DONE: state <= HOLD;
                // busy is already up here for a positive droplet
                HOLD: begin
                    if (!sort_busy_i) begin
                        state <= WAIT;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // peak and width, no reset needed
    always_ff @(posedge adc_clk_i) begin
        if (state == WAIT && above) begin
            drop_width_o <= 32'd1;
            drop_peak_o <= adc_a_i;
        end else if (state == ACQUIRE && above) begin
            // only samples inside the run count
            drop_width_o <= drop_width_o + 32'd1;
            if (adc_a_i > drop_peak_o) begin
                drop_peak_o <= adc_a_i;
            end
        end
    end

    // strobe one cycle after the closing sample
    assign drop_done_o = state == DONE;

endmodule

//--- hw/fads_regs.sv
// register bank; only address bits 19:0 decoded, ack and data one cycle after the request
`timescale 1ns/1ns

module fads_regs (
    input  logic                adc_clk_i,
    input  logic                fads_reset,
    input  fads_pkg::bus_data_t sys_addr_i,
    input  fads_pkg::bus_data_t sys_wdata_i,
    input  logic                sys_wen_i,
    input  logic                sys_ren_i,
    input  fads_pkg::count_t    cnt_low_int_i,
    input  fads_pkg::count_t    cnt_high_int_i,
    input  fads_pkg::count_t    cnt_short_i,
    input  fads_pkg::count_t    cnt_long_i,
    input  fads_pkg::count_t    cnt_pos_i,
    input  fads_pkg::count_t    cnt_neg_i,
    input  fads_pkg::count_t    drop_id_i,
    input  fads_pkg::sample_t   last_peak_i,
    input  fads_pkg::width_t    last_width_i,
    input  fads_pkg::class_t    last_class_i,
    output fads_pkg::bus_data_t sys_rdata_o,
    output logic                sys_ack_o,
    output fads_pkg::sample_t   min_int_o,
    output fads_pkg::sample_t   low_int_o,
    output fads_pkg::sample_t   high_int_o,
    output fads_pkg::width_t    min_w_o,
    output fads_pkg::width_t    low_w_o,
    output fads_pkg::width_t    high_w_o,
    output fads_pkg::width_t    sort_delay_o,
    output fads_pkg::width_t    sort_dur_o
);

    fads_pkg::bus_addr_t addr;
    fads_pkg::bus_data_t rdata;

    assign addr = sys_addr_i[19:0];

    // writes land at the request edge
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            min_int_o <= fads_pkg::RST_MIN_INT;
            low_int_o <= fads_pkg::RST_LOW_INT;
            high_int_o <= fads_pkg::RST_HIGH_INT;
            min_w_o <= fads_pkg::RST_MIN_W;
            low_w_o <= fads_pkg::RST_LOW_W;
            high_w_o <= fads_pkg::RST_HIGH_W;
            sort_delay_o <= fads_pkg::RST_SORT_DELAY;
            sort_dur_o <= fads_pkg::RST_SORT_DUR;
        end else if (sys_wen_i) begin
            case (addr)
                // intensity keeps the low 14 bits only
                fads_pkg::ADDR_MIN_INT: min_int_o <= sys_wdata_i[13:0];
                fads_pkg::ADDR_LOW_INT: low_int_o <= sys_wdata_i[13:0];
                fads_pkg::ADDR_HIGH_INT: high_int_o <= sys_wdata_i[13:0];
                fads_pkg::ADDR_MIN_W: min_w_o <= sys_wdata_i;
                fads_pkg::ADDR_LOW_W: low_w_o <= sys_wdata_i;
                fads_pkg::ADDR_HIGH_W: high_w_o <= sys_wdata_i;
                fads_pkg::ADDR_SORT_DELAY: sort_delay_o <= sys_wdata_i;
                fads_pkg::ADDR_SORT_DUR: sort_dur_o <= sys_wdata_i;
                default: ;
            endcase
        end
    end

    // readback mux
    always_comb begin
        case (addr)
            // thresholds read back as raw 14-bit fields
            fads_pkg::ADDR_MIN_INT: rdata = {18'd0, min_int_o};
            fads_pkg::ADDR_LOW_INT: rdata = {18'd0, low_int_o};
            fads_pkg::ADDR_HIGH_INT: rdata = {18'd0, high_int_o};
            fads_pkg::ADDR_MIN_W: rdata = min_w_o;
            fads_pkg::ADDR_LOW_W: rdata = low_w_o;
            fads_pkg::ADDR_HIGH_W: rdata = high_w_o;
            fads_pkg::ADDR_SORT_DELAY: rdata = sort_delay_o;
            fads_pkg::ADDR_SORT_DUR: rdata = sort_dur_o;
            fads_pkg::ADDR_CNT_LOW_INT: rdata = cnt_low_int_i;
            fads_pkg::ADDR_CNT_HIGH_INT: rdata = cnt_high_int_i;
            fads_pkg::ADDR_CNT_SHORT: rdata = cnt_short_i;
            fads_pkg::ADDR_CNT_LONG: rdata = cnt_long_i;
            fads_pkg::ADDR_CNT_POS: rdata = cnt_pos_i;
            fads_pkg::ADDR_CNT_NEG: rdata = cnt_neg_i;
            fads_pkg::ADDR_DROP_ID: rdata = drop_id_i;
            // peak is signed, keep the sign in the word
            fads_pkg::ADDR_DROP_INT: rdata = {{18{last_peak_i[13]}}, last_peak_i};
            fads_pkg::ADDR_DROP_W: rdata = last_width_i;
            fads_pkg::ADDR_DROP_CLASS: rdata = {24'd0, last_class_i};
            // unmapped reads as zero
            default: rdata = '0;
        endcase
    end

    // ack for reads and writes alike
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            sys_ack_o <= 1'b0;
        end else begin
            sys_ack_o <= sys_wen_i | sys_ren_i;
        end
    end

    // payload register, valid with ack
    always_ff @(posedge adc_clk_i) begin
        sys_rdata_o <= rdata;
    end

endmodule

//--- hw/fads_top.sv
// sorter core top; one adc channel, samples ignored while a sort pulse is pending or active
`timescale 1ns/1ns

module fads_top (
    input  logic                adc_clk_i,
    input  logic                fads_reset,
    input  fads_pkg::sample_t   adc_a_i,
    input  fads_pkg::bus_data_t sys_addr_i,
    input  fads_pkg::bus_data_t sys_wdata_i,
    input  logic                sys_wen_i,
    input  logic                sys_ren_i,
    output fads_pkg::bus_data_t sys_rdata_o,
    output logic                sys_ack_o,
    output logic                sort_trig_o
);

    // thresholds and timing from the register bank
    fads_pkg::sample_t min_int;
    fads_pkg::sample_t low_int;
    fads_pkg::sample_t high_int;
    fads_pkg::width_t  min_w;
    fads_pkg::width_t  low_w;
    fads_pkg::width_t  high_w;
    fads_pkg::width_t  sort_delay;
    fads_pkg::width_t  sort_dur;

    // detector result
    logic              drop_done;
    fads_pkg::sample_t drop_peak;
    fads_pkg::width_t  drop_width;

    // statistics and record for readback
    fads_pkg::count_t  cnt_low_int;
    fads_pkg::count_t  cnt_high_int;
    fads_pkg::count_t  cnt_short;
    fads_pkg::count_t  cnt_long;
    fads_pkg::count_t  cnt_pos;
    fads_pkg::count_t  cnt_neg;
    fads_pkg::count_t  drop_id;
    fads_pkg::sample_t last_peak;
    fads_pkg::width_t  last_width;
    fads_pkg::class_t  last_class;

    logic sort_start;
    logic sort_busy;

    fads_regs u_regs (
        .adc_clk_i      (adc_clk_i),
        .fads_reset     (fads_reset),
        .sys_addr_i     (sys_addr_i),
        .sys_wdata_i    (sys_wdata_i),
        .sys_wen_i      (sys_wen_i),
        .sys_ren_i      (sys_ren_i),
        .cnt_low_int_i  (cnt_low_int),
        .cnt_high_int_i (cnt_high_int),
        .cnt_short_i    (cnt_short),
        .cnt_long_i     (cnt_long),
        .cnt_pos_i      (cnt_pos),
        .cnt_neg_i      (cnt_neg),
        .drop_id_i      (drop_id),
        .last_peak_i    (last_peak),
        .last_width_i   (last_width),
        .last_class_i   (last_class),
        .sys_rdata_o    (sys_rdata_o),
        .sys_ack_o      (sys_ack_o),
        .min_int_o      (min_int),
        .low_int_o      (low_int),
        .high_int_o     (high_int),
        .min_w_o        (min_w),
        .low_w_o        (low_w),
        .high_w_o       (high_w),
        .sort_delay_o   (sort_delay),
        .sort_dur_o     (sort_dur)
    );

    droplet_detector u_detector (
        .adc_clk_i    (adc_clk_i),
        .fads_reset   (fads_reset),
        .adc_a_i      (adc_a_i),
        .min_int_i    (min_int),
        .sort_busy_i  (sort_busy),
        .drop_done_o  (drop_done),
        .drop_peak_o  (drop_peak),
        .drop_width_o (drop_width)
    );

    droplet_classifier u_classifier (
        .adc_clk_i      (adc_clk_i),
        .fads_reset     (fads_reset),
        .drop_done_i    (drop_done),
        .drop_peak_i    (drop_peak),
        .drop_width_i   (drop_width),
        .low_int_i      (low_int),
        .high_int_i     (high_int),
        .min_w_i        (min_w),
        .low_w_i        (low_w),
        .high_w_i       (high_w),
        .cnt_low_int_o  (cnt_low_int),
        .cnt_high_int_o (cnt_high_int),
        .cnt_short_o    (cnt_short),
        .cnt_long_o     (cnt_long),
        .cnt_pos_o      (cnt_pos),
        .cnt_neg_o      (cnt_neg),
        .drop_id_o      (drop_id),
        .last_peak_o    (last_peak),
        .last_width_o   (last_width),
        .last_class_o   (last_class),
        .sort_start_o   (sort_start)
    );

    sort_pulse u_sort (
        .adc_clk_i    (adc_clk_i),
        .fads_reset   (fads_reset),
        .sort_start_i (sort_start),
        .sort_delay_i (sort_delay),
        .sort_dur_i   (sort_dur),
        .sort_busy_o  (sort_busy),
        .sort_trig_o  (sort_trig_o)
    );

endmodule

//--- hw/sort_pulse.sv
// sort timer; trigger rises delay+1 cycles after start for dur cycles, zero delay or dur acts as one
`timescale 1ns/1ns

module sort_pulse (
    input  logic             adc_clk_i,
    input  logic             fads_reset,
    input  logic             sort_start_i,
    input  fads_pkg::width_t sort_delay_i,
    input  fads_pkg::width_t sort_dur_i,
    output logic             sort_busy_o,
    output logic             sort_trig_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DELAY,
        S_FIRE
    } sort_state_t;

    sort_state_t      state;
    fads_pkg::width_t cnt;

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state <= S_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                // start requests while busy are dropped
                S_IDLE: begin
                    if (sort_start_i) begin
                        state <= S_DELAY;
                        cnt <= 32'd1;
                    end
                end
                // cnt counts cycles spent in the state, from 1
                S_DELAY: begin
                    if (cnt >= sort_delay_i) begin
                        state <= S_FIRE;
                        cnt <= 32'd1;
                    end else begin
                        cnt <= cnt + 32'd1;
                    end
                end
                S_FIRE: begin
                    if (cnt >= sort_dur_i) begin
                        state <= S_IDLE;
                    end else begin
                        cnt <= cnt + 32'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign sort_busy_o = state != S_IDLE;
    assign sort_trig_o = state == S_FIRE;

endmodule

//--- tb.f
+incdir+test
common/fads_pkg.sv
hw/fads_regs.sv
droplet/droplet_detector.sv
droplet/droplet_classifier.sv
hw/sort_pulse.sv
hw/fads_top.sv
test/tb_fads.sv

//--- test/fads_model.svh
// band rule reference for tb_fads, included in its body; thresholds assumed min <= low <= high
`ifndef FADS_MODEL_SVH
`define FADS_MODEL_SVH

// thresholds in force while droplets run, the register reset values
int m_min_int = 15;
int m_low_int = 16;
int m_high_int = 255;
int m_min_w = 1;
int m_low_w = 4;
int m_high_w = 40;

// expected statistics
int m_cnt_low_int;
int m_cnt_high_int;
int m_cnt_short;
int m_cnt_long;
int m_cnt_pos;
int m_cnt_neg;

// expected last-droplet record
int m_drop_id;
int m_last_peak;
int m_last_width;
logic [7:0] m_last_class;

function automatic logic [7:0] classify_droplet(input int peak, input int width);
    logic [7:0] cls;
    cls = 8'h00;
    // intensity bands
    cls[0] = peak >= m_min_int && peak < m_low_int;
    cls[1] = peak >= m_low_int && peak < m_high_int;
    cls[2] = peak >= m_high_int;
    // width bands, nothing below min_w
    cls[3] = width >= m_min_w && width < m_low_w;
    cls[4] = width >= m_low_w && width < m_high_w;
    cls[5] = width >= m_high_w;
    // positive needs both middle bands
    cls[7] = cls[1] && cls[4];
    return cls;
endfunction

task automatic model_droplet(input int peak, input int width, input logic [7:0] cls);
    logic has_width;
    has_width = cls[3] || cls[4] || cls[5];
    m_cnt_low_int += int'(cls[0]);
    m_cnt_high_int += int'(cls[2]);
    m_cnt_short += int'(cls[3]);
    m_cnt_long += int'(cls[5]);
    m_cnt_pos += int'(cls[7]);
    // negative means any width class but not positive
    m_cnt_neg += int'(has_width && !cls[7]);
    if (has_width) begin
        m_drop_id++;
        m_last_peak = peak;
        m_last_width = width;
        m_last_class = cls;
    end
endtask

task automatic model_clear();
    m_cnt_low_int = 0;
    m_cnt_high_int = 0;
    m_cnt_short = 0;
    m_cnt_long = 0;
    m_cnt_pos = 0;
    m_cnt_neg = 0;
    m_drop_id = 0;
    m_last_peak = 0;
    m_last_width = 0;
    m_last_class = 8'h00;
endtask

`endif

//--- test/tb_fads.sv
// testbench for fads_top; droplets spaced wider than the sort time, so no back-pressure is hit
`timescale 1ns/1ns

module tb_fads;

    localparam int NUM_DROPS = 200;
    localparam int MAX_LEN = 60;
    localparam int GAP = 30;
    localparam int SORT_DELAY = 6;
    localparam int SORT_DUR = 10;
    // lead-in, run, gap and record readback per droplet, plus register traffic
    localparam int TIMEOUT_CYCLES = NUM_DROPS * (4 + MAX_LEN + GAP + 16) + 1000;

    logic              adc_clk;
    logic              fads_reset;
    fads_pkg::sample_t adc_a;
    logic [31:0]       sys_addr;
    logic [31:0]       sys_wdata;
    logic              sys_wen;
    logic              sys_ren;
    logic [31:0]       sys_rdata;
    logic              sys_ack;
    logic              sort_trig;

    integer seed = 32'h2d96;
    int cycle_cnt = 0;
    int mismatch_errors = 0;
    int other_errors = 0;
    // trigger monitor state
    int rise_queue[$];
    int pulse_cnt = 0;
    int pulse_start = 0;
    int exp_rise;
    logic trig_prev = 1'b0;

    `include "fads_model.svh"

    fads_top DUT (
        .adc_clk_i   (adc_clk),
        .fads_reset  (fads_reset),
        .adc_a_i     (adc_a),
        .sys_addr_i  (sys_addr),
        .sys_wdata_i (sys_wdata),
        .sys_wen_i   (sys_wen),
        .sys_ren_i   (sys_ren),
        .sys_rdata_o (sys_rdata),
        .sys_ack_o   (sys_ack),
        .sort_trig_o (sort_trig)
    );

    // 40 ns period
    always #20 adc_clk = ~adc_clk;

    always @(posedge adc_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic drive_sample(input int value);
        @(posedge adc_clk);
        #2;
        adc_a = value[13:0];
    endtask

    // one request cycle, ack expected in the next cycle only
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                              input logic write, output logic [31:0] rdata);
        @(posedge adc_clk);
        #2;
        sys_addr = addr;
        sys_wdata = data;
        sys_wen = write;
        sys_ren = !write;
        @(negedge adc_clk);
        assert (sys_ack === 1'b0) else begin
            other_errors++;
            $display("ERROR at %0t: sys_ack_o high in the request cycle to %h", $time, addr);
        end
        @(posedge adc_clk);
        #2;
        sys_wen = 1'b0;
        sys_ren = 1'b0;
        @(negedge adc_clk);
        assert (sys_ack === 1'b1) else begin
            other_errors++;
            $display("ERROR at %0t: no sys_ack_o the cycle after a request to %h", $time, addr);
        end
        rdata = sys_rdata;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(addr, data, 1'b1, unused);
    endtask

    task automatic read_and_compare(input string name, input logic [31:0] addr,
                                    input logic [31:0] exp);
        logic [31:0] got;
        bus_access(addr, 32'h0, 1'b0, got);
        compare_word(name, got, exp);
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge adc_clk);
        #2;
        fads_reset = 1'b1;
        repeat (cycles) @(posedge adc_clk);
        #2;
        fads_reset = 1'b0;
        model_clear();
    endtask

    task automatic check_record();
        read_and_compare("DROP_ID", fads_pkg::ADDR_DROP_ID, m_drop_id);
        // peak comes back sign extended
        read_and_compare("DROP_INT", fads_pkg::ADDR_DROP_INT, m_last_peak);
        read_and_compare("DROP_W", fads_pkg::ADDR_DROP_W, m_last_width);
        read_and_compare("DROP_CLASS", fads_pkg::ADDR_DROP_CLASS, {24'd0, m_last_class});
    endtask

    task automatic check_counters();
        read_and_compare("CNT_LOW_INT", fads_pkg::ADDR_CNT_LOW_INT, m_cnt_low_int);
        read_and_compare("CNT_HIGH_INT", fads_pkg::ADDR_CNT_HIGH_INT, m_cnt_high_int);
        read_and_compare("CNT_SHORT", fads_pkg::ADDR_CNT_SHORT, m_cnt_short);
        read_and_compare("CNT_LONG", fads_pkg::ADDR_CNT_LONG, m_cnt_long);
        read_and_compare("CNT_POS", fads_pkg::ADDR_CNT_POS, m_cnt_pos);
        read_and_compare("CNT_NEG", fads_pkg::ADDR_CNT_NEG, m_cnt_neg);
    endtask

    // thresholds at reset values, statistics and record all zero
    task automatic check_reset_state();
        read_and_compare("MIN_INT", fads_pkg::ADDR_MIN_INT, 32'd15);
        read_and_compare("LOW_INT", fads_pkg::ADDR_LOW_INT, 32'd16);
        read_and_compare("HIGH_INT", fads_pkg::ADDR_HIGH_INT, 32'd255);
        read_and_compare("MIN_W", fads_pkg::ADDR_MIN_W, 32'd1);
        read_and_compare("LOW_W", fads_pkg::ADDR_LOW_W, 32'd4);
        read_and_compare("HIGH_W", fads_pkg::ADDR_HIGH_W, 32'd40);
        read_and_compare("SORT_DELAY", fads_pkg::ADDR_SORT_DELAY, 32'd31250);
        read_and_compare("SORT_DUR", fads_pkg::ADDR_SORT_DUR, 32'd125000);
        check_counters();
        check_record();
    endtask

    task automatic register_test();
        logic [31:0] addrs [8];
        logic [31:0] wdata;
        logic [31:0] mask;
        int i;
        addrs = '{fads_pkg::ADDR_MIN_INT, fads_pkg::ADDR_LOW_INT, fads_pkg::ADDR_HIGH_INT,
                  fads_pkg::ADDR_MIN_W, fads_pkg::ADDR_LOW_W, fads_pkg::ADDR_HIGH_W,
                  fads_pkg::ADDR_SORT_DELAY, fads_pkg::ADDR_SORT_DUR};
        for (i = 0; i < 8; i++) begin
            wdata = $random(seed);
            // intensity registers hold 14 bits
            mask = (i < 3) ? 32'h0000_3fff : 32'hffff_ffff;
            // the held sample is the most negative value, keep min_int above it
            if (i == 0 && wdata[13:0] == 14'h2000) begin
                wdata[0] = 1'b1;
            end
            bus_write(addrs[i], wdata);
            read_and_compare($sformatf("register %h", addrs[i]), addrs[i], wdata & mask);
        end
        read_and_compare("unmapped 0x00C", 32'h0000_000c, 32'h0);
        read_and_compare("unmapped 0x030", 32'h0000_0030, 32'h0);
        read_and_compare("unmapped 0x300", 32'h0000_0300, 32'h0);
    endtask

    task automatic apply_droplet(input int idx);
        int len;
        int peak;
        int peak_pos;
        int lead;
        int i;
        logic [7:0] cls;
        len = rand_range(1, MAX_LEN);
        peak = rand_range(15, 400);
        peak_pos = rand_range(0, len - 1);
        lead = rand_range(2, 4);
        cls = classify_droplet(peak, len);
        for (i = 0; i < lead; i++) begin
            drive_sample(rand_range(-40, 14));
        end
        // run samples never exceed the peak
        for (i = 0; i < len; i++) begin
            if (i == peak_pos) begin
                drive_sample(peak);
            end else begin
                drive_sample(rand_range(15, peak));
            end
        end
        // first baseline sample closes the run, trigger 8 cycles later
        drive_sample(rand_range(-40, 14));
        if (cls[7]) begin
            rise_queue.push_back(cycle_cnt + SORT_DELAY + 2);
        end
        model_droplet(peak, len, cls);
        for (i = 1; i < GAP; i++) begin
            drive_sample(rand_range(-40, 14));
        end
        if (idx % 10 == 0 || idx == NUM_DROPS - 1) begin
            check_record();
        end
    endtask

    // sort trigger monitor, sampled mid cycle
    always @(negedge adc_clk) begin
        if (!fads_reset) begin
            if (sort_trig === 1'b1 && trig_prev === 1'b0) begin
                pulse_cnt++;
                pulse_start = cycle_cnt;
                assert (rise_queue.size() > 0) else begin
                    other_errors++;
                    $display("ERROR at %0t: sort trigger fired with no positive droplet", $time);
                end
                if (rise_queue.size() > 0) begin
                    exp_rise = rise_queue.pop_front();
                    compare_word("sort_trig_o rise cycle", cycle_cnt, exp_rise);
                end
            end
            if (sort_trig === 1'b0 && trig_prev === 1'b1) begin
                compare_word("sort_trig_o pulse length", cycle_cnt - pulse_start, SORT_DUR);
            end
        end
        trig_prev = sort_trig;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("ERROR: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int d;
        adc_clk = 1'b0;
        fads_reset = 1'b1;
        adc_a = 14'h2000;
        sys_addr = 32'h0;
        sys_wdata = 32'h0;
        sys_wen = 1'b0;
        sys_ren = 1'b0;
        repeat (8) @(posedge adc_clk);
        #2;
        fads_reset = 1'b0;
        model_clear();
        check_reset_state();
        register_test();
        // random register values undone by reset
        apply_reset(4);
        check_reset_state();
        bus_write(fads_pkg::ADDR_SORT_DELAY, SORT_DELAY);
        bus_write(fads_pkg::ADDR_SORT_DUR, SORT_DUR);
        for (d = 0; d < NUM_DROPS; d++) begin
            apply_droplet(d);
        end
        check_counters();
        compare_word("sort trigger pulse count", pulse_cnt, m_cnt_pos);
        assert (rise_queue.size() == 0) else begin
            other_errors++;
            $display("ERROR: %0d expected sort pulses never came", rise_queue.size());
        end
        // reset with nonzero statistics
        apply_reset(4);
        check_reset_state();
        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
